/* filelist.f */
verilog/rob_pkg.sv
verilog/reorder_buffer.sv
verilog/op_dispatch.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/write_arbiter.sv
verilog/rob_core_top.sv
verif/rob_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the reorder-buffer core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary -j 0 --top-module rob_tb -f filelist.f
output=$(./obj_dir/Vrob_tb 2>&1) || true
echo "$output"
if echo "$output" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

/* verif/rob_tb.sv */
// --------------------
// Self-checking testbench for the reorder-buffer core.
// Runs corner cases per opcode, an ordering case, a full-buffer stall
// and a random stream, and checks each result against a reference model.
// Build it with the file list, top module rob_tb.
// --------------------
`timescale 1ns/1ps
`default_nettype none

module rob_tb
  import rob_pkg::*;
();

  localparam int CLOCK_HALF_NS   = 50;
  localparam int CLOCK_PERIOD_NS = 2 * CLOCK_HALF_NS;
  localparam int RANDOM_OPS      = 300;
  localparam int CYCLES_PER_OP   = 20;
  localparam int WATCHDOG_NS     = RANDOM_OPS * CYCLES_PER_OP * CLOCK_PERIOD_NS;
  localparam int STALL_CYCLES    = 10;

  // Result side modes
  localparam int TAKE_LOW    = 0;
  localparam int TAKE_HIGH   = 1;
  localparam int TAKE_RANDOM = 2;

  logic                    clock;
  logic                    resetn;
  logic                    op_issue;
  op_req_t                 op_req;
  logic                    op_busy;
  logic                    result_valid;
  logic [RESULT_WIDTH-1:0] result_data;
  logic                    result_take;
  logic                    rob_idle;

  // Only the main process steps the LFSR
  logic [7:0]              lfsr_state;
  int                      take_mode;
  // Expected results in issue order
  logic [RESULT_WIDTH-1:0] expected_q [$];
  logic [RESULT_WIDTH-1:0] head_value;

  rob_core_top DUT (
    .clock        (clock),
    .resetn       (resetn),
    .op_issue     (op_issue),
    .op_req       (op_req),
    .op_busy      (op_busy),
    .result_valid (result_valid),
    .result_data  (result_data),
    .result_take  (result_take),
    .rob_idle     (rob_idle)
  );

  always #(CLOCK_HALF_NS) clock = ~clock;

  // Galois form of x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] state);
    lfsr_step = state[0] ? ((state >> 1) ^ 8'hB8) : (state >> 1);
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int count, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits = {bits[14:0], lfsr_state[0]};
    end
  endtask

  // Reference model that zero-extends and then operates
  function automatic logic [RESULT_WIDTH-1:0] expected_result(input op_req_t req);
    logic [RESULT_WIDTH-1:0] a;
    logic [RESULT_WIDTH-1:0] b;
    a = RESULT_WIDTH'(req.operand_a);
    b = RESULT_WIDTH'(req.operand_b);
    case (req.opcode)
      OP_ADD:  expected_result = a + b;
      OP_SUB:  expected_result = a - b;
      OP_XOR:  expected_result = a ^ b;
      default: expected_result = a * b;
    endcase
  endfunction

  function automatic op_req_t make_req(input opcode_t opcode, input logic [7:0] a,
                                       input logic [7:0] b);
    op_req_t req;
    req.opcode    = opcode;
    req.operand_a = a;
    req.operand_b = b;
    make_req = req;
  endfunction

  function automatic logic [7:0] corner_value(input int k);
    case (k)
      0:       corner_value = 8'h00;
      1:       corner_value = 8'h01;
      default: corner_value = 8'hFF;
    endcase
  endfunction

  task automatic report_failure();
    $display("*** FAILED ***");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected) begin
      $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
      report_failure();
    end
  endtask

  // Advance one edge and drive result_take for the coming cycle
  task automatic tick();
    logic [15:0] bits;
    @(posedge clock);
    case (take_mode)
      TAKE_LOW:  result_take <= 1'b0;
      TAKE_HIGH: result_take <= 1'b1;
      default: begin
        // Take about three cycles out of four
        take_bits(2, bits);
        result_take <= (bits[1:0] != 2'b00);
      end
    endcase
  endtask

  // Entered and left just after a rising edge
  task automatic issue_op(input op_req_t req);
    op_req   <= req;
    op_issue <= 1'b0;
    @(negedge clock);
    // op_busy follows the offered opcode
    while (op_busy) begin
      tick();
      @(negedge clock);
    end
    tick();
    op_issue <= 1'b1;
    expected_q.push_back(expected_result(req));
    // The strobe cycle itself must see a free core
    @(negedge clock);
    check_value("op_busy", 16'(op_busy), 16'd0);
    tick();
    op_issue <= 1'b0;
  endtask

  task automatic drain_results();
    while (expected_q.size() != 0) begin
      tick();
    end
    @(negedge clock);
    check_value("rob_idle", 16'(rob_idle), 16'd1);
    check_value("result_valid", 16'(result_valid), 16'd0);
    tick();
  endtask

  // Compare on every cycle that retires the head
  always @(negedge clock) begin
    if (resetn && result_valid) begin
      if (expected_q.size() == 0) begin
        $display("result_valid went high while no result was expected at %0t", $time);
        report_failure();
      end else if (result_take) begin
        head_value = expected_q.pop_front();
        check_value("result_data", result_data, head_value);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Run timed out after %0d ns with results still missing", WATCHDOG_NS);
    report_failure();
  end

  initial begin
    op_req_t     req;
    logic [15:0] bits;
    clock        = 1'b0;
    resetn       = 1'b0;
    op_issue     = 1'b0;
    op_req       = '0;
    result_take  = 1'b0;
    lfsr_state   = 8'd97;
    take_mode    = TAKE_LOW;
    repeat (2) @(posedge clock);
    resetn <= 1'b1;

    // Quiet state right after reset
    @(negedge clock);
    check_value("op_busy", 16'(op_busy), 16'd0);
    check_value("result_valid", 16'(result_valid), 16'd0);
    check_value("rob_idle", 16'(rob_idle), 16'd1);
    tick();

    // Every opcode on 0, 1 and 255
    take_mode = TAKE_HIGH;
    for (int op = 0; op < 4; op++) begin
      for (int i = 0; i < 3; i++) begin
        for (int j = 0; j < 3; j++) begin
          issue_op(make_req(opcode_t'(op[1:0]), corner_value(i), corner_value(j)));
        end
      end
    end
    drain_results();

    // Long multiply ahead of quick ALU work still retires first
    issue_op(make_req(OP_MUL, 8'hC8, 8'h03));
    issue_op(make_req(OP_ADD, 8'h12, 8'h34));
    issue_op(make_req(OP_SUB, 8'h05, 8'h09));
    issue_op(make_req(OP_XOR, 8'hA5, 8'h5A));
    issue_op(make_req(OP_ADD, 8'hFF, 8'hFF));
    drain_results();

    // Buffer fills with takes held off and stalls the issue side
    take_mode = TAKE_LOW;
    for (int i = 0; i < ROB_DEPTH; i++) begin
      issue_op(make_req(OP_ADD, 8'(i), 8'h03));
    end
    op_req <= make_req(OP_SUB, 8'h10, 8'h01);
    repeat (STALL_CYCLES) begin
      @(negedge clock);
      check_value("op_busy", 16'(op_busy), 16'd1);
      tick();
    end
    take_mode = TAKE_HIGH;
    issue_op(make_req(OP_SUB, 8'h10, 8'h01));
    issue_op(make_req(OP_MUL, 8'hFF, 8'hFF));
    drain_results();

    // Random stream with random back-pressure
    take_mode = TAKE_RANDOM;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      take_bits(1, bits);
      if (bits[0]) begin
        tick();
      end
      take_bits(2, bits);
      req.opcode = opcode_t'(bits[1:0]);
      take_bits(8, bits);
      req.operand_a = bits[7:0];
      take_bits(8, bits);
      req.operand_b = bits[7:0];
      issue_op(req);
    end
    drain_results();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/rob_core_top.sv */
// --------------------
// Top level of the out-of-order arithmetic core.
// Operations go in with op_issue while op_busy is low. Results come out
// in issue order on result_valid and are consumed with result_take.
// --------------------
`timescale 1ns/1ps
`default_nettype none

module rob_core_top
  import rob_pkg::*;
(
  input  wire                     clock,
  input  wire                     resetn,
  input  wire                     op_issue,
  input  op_req_t                 op_req,
  output logic                    op_busy,
  output logic                    result_valid,
  output logic [RESULT_WIDTH-1:0] result_data,
  input  wire                     result_take,
  output logic                    rob_idle
);

  // Dispatch to buffer
  logic                       reserve;
  logic [ROB_INDEX_WIDTH-1:0] reserve_index;
  logic                       reserve_full;

  // Dispatch to units
  unit_req_t unit_req;
  logic      alu_start;
  logic      mul_start;
  logic      alu_busy;
  logic      mul_busy;

  // Units to arbiter
  logic         alu_done;
  logic         mul_done;
  unit_result_t alu_result;
  unit_result_t mul_result;
  logic         alu_grant;
  logic         mul_grant;

  // Arbiter to buffer
  logic         write_enable;
  unit_result_t write_result;

  op_dispatch u_dispatch (
    .clock         (clock),
    .resetn        (resetn),
    .op_issue      (op_issue),
    .op_req        (op_req),
    .op_busy       (op_busy),
    .reserve       (reserve),
    .reserve_index (reserve_index),
    .reserve_full  (reserve_full),
    .alu_busy      (alu_busy),
    .mul_busy      (mul_busy),
    .alu_start     (alu_start),
    .mul_start     (mul_start),
    .unit_req      (unit_req)
  );

  alu_unit u_alu (
    .clock    (clock),
    .resetn   (resetn),
    .start    (alu_start),
    .unit_req (unit_req),
    .busy     (alu_busy),
    .done     (alu_done),
    .result   (alu_result),
    .grant    (alu_grant)
  );

  mul_unit u_mul (
    .clock    (clock),
    .resetn   (resetn),
    .start    (mul_start),
    .unit_req (unit_req),
    .busy     (mul_busy),
    .done     (mul_done),
    .result   (mul_result),
    .grant    (mul_grant)
  );

  write_arbiter u_arbiter (
    .clock        (clock),
    .resetn       (resetn),
    .alu_done     (alu_done),
    .alu_result   (alu_result),
    .mul_done     (mul_done),
    .mul_result   (mul_result),
    .alu_grant    (alu_grant),
    .mul_grant    (mul_grant),
    .write_enable (write_enable),
    .write_result (write_result)
  );

  // Idle means nothing reserved
  reorder_buffer u_rob (
    .clock         (clock),
    .resetn        (resetn),
    .reserve       (reserve),
    .reserve_index (reserve_index),
    .reserve_full  (reserve_full),
    .reserve_empty (rob_idle),
    .write_enable  (write_enable),
    .write_result  (write_result),
    .read_valid    (result_valid),
    .read_data     (result_data),
    .read_enable   (result_take)
  );

endmodule

`default_nettype wire

/* verilog/write_arbiter.sv */
// --------------------
// Round-robin arbiter for the reorder buffer's single write port.
// Grants one finished unit per cycle. On a tie the unit not granted
// last wins, ALU first out of reset. A loser keeps its result waiting.
// --------------------
`timescale 1ns/1ps
`default_nettype none

module write_arbiter
  import rob_pkg::*;
(
  input  wire          clock,
  input  wire          resetn,
  input  wire          alu_done,
  input  unit_result_t alu_result,
  input  wire          mul_done,
  input  unit_result_t mul_result,
  output logic         alu_grant,
  output logic         mul_grant,
  output logic         write_enable,
  output unit_result_t write_result
);

  // Set when the multiplier won most recently
  logic last_was_mul;

  // ALU wins when alone or when it is its turn
  assign alu_grant = alu_done & (~mul_done | last_was_mul);
  assign mul_grant = mul_done & ~alu_grant;

  assign write_enable = alu_grant | mul_grant;
  assign write_result = mul_grant ? mul_result : alu_result;

  // Reset as if the multiplier went last
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      last_was_mul <= 1'b1;
    end else if (write_enable) begin
      last_was_mul <= mul_grant;
    end
  end

endmodule

`default_nettype wire

/* verilog/mul_unit.sv */
// --------------------
// Iterative shift-add multiplier.
// One multiplier bit per cycle, the first one on the start edge, so done
// rises MUL_CYCLES cycles after start. The product holds until granted.
// --------------------
`timescale 1ns/1ps
`default_nettype none

module mul_unit
  import rob_pkg::*;
(
  input  wire          clock,
  input  wire          resetn,
  input  wire          start,
  input  unit_req_t    unit_req,
  output logic         busy,
  output logic         done,
  output unit_result_t result,
  input  wire          grant
);

  localparam int PAD_WIDTH = RESULT_WIDTH - OPERAND_WIDTH;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    HOLD
  } mul_state_t;

  mul_state_t                 state;
  logic [MUL_COUNT_WIDTH-1:0] step_count;

  // Datapath registers
  logic [RESULT_WIDTH-1:0]    product;
  logic [RESULT_WIDTH-1:0]    multiplicand;
  logic [OPERAND_WIDTH-1:0]   multiplier;
  logic [ROB_INDEX_WIDTH-1:0] tag_q;

  // Step operands, taken from the request while idle
  logic [RESULT_WIDTH-1:0]  step_acc;
  logic [RESULT_WIDTH-1:0]  step_mcand;
  logic [OPERAND_WIDTH-1:0] step_mult;
  logic [RESULT_WIDTH-1:0]  step_sum;
  logic                     step_en;

  always_comb begin
    if (state == IDLE) begin
      step_acc   = '0;
      step_mcand = {{PAD_WIDTH{1'b0}}, unit_req.operand_a};
      step_mult  = unit_req.operand_b;
    end else begin
      step_acc   = product;
      step_mcand = multiplicand;
      step_mult  = multiplier;
    end
  end

  // The single adder
  assign step_sum = step_acc + (step_mult[0] ? step_mcand : '0);
  assign step_en  = (state == IDLE && start) || state == RUN;

  assign busy = state != IDLE;
  assign done = state == HOLD;
  assign result.tag  = tag_q;
  assign result.data = product;

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      state      <= IDLE;
      step_count <= '0;
    end else begin
      case (state)
        IDLE: if (start) begin
          state      <= RUN;
          step_count <= MUL_COUNT_WIDTH'(1);
        end
        RUN: begin
          step_count <= step_count + 1'b1;
          // Last bit consumed on this edge
          if (step_count == MUL_COUNT_WIDTH'(MUL_CYCLES - 1)) begin
            state <= HOLD;
          end
        end
        HOLD: if (grant) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (step_en) begin
      product      <= step_sum;
      multiplicand <= step_mcand << 1;
      multiplier   <= step_mult >> 1;
    end
    if (state == IDLE && start) begin
      tag_q <= unit_req.tag;
    end
  end

endmodule

`default_nettype wire

/* verilog/alu_unit.sv */
// --------------------
// Single-cycle add, subtract and xor unit.
// Result is registered at the start edge and done rises the next cycle.
// Done and the result hold until the write arbiter grants them.
// --------------------
`timescale 1ns/1ps
`default_nettype none

module alu_unit
  import rob_pkg::*;
(
  input  wire          clock,
  input  wire          resetn,
  input  wire          start,
  input  unit_req_t    unit_req,
  output logic         busy,
  output logic         done,
  output unit_result_t result,
  input  wire          grant
);

  localparam int PAD_WIDTH = RESULT_WIDTH - OPERAND_WIDTH;

  logic [RESULT_WIDTH-1:0] a_ext;
  logic [RESULT_WIDTH-1:0] b_ext;
  logic [RESULT_WIDTH-1:0] alu_value;

  // Zero-extend operands first
  assign a_ext = {{PAD_WIDTH{1'b0}}, unit_req.operand_a};
  assign b_ext = {{PAD_WIDTH{1'b0}}, unit_req.operand_b};

  always_comb begin
    case (unit_req.opcode)
      OP_ADD:  alu_value = a_ext + b_ext;
      OP_SUB:  alu_value = a_ext - b_ext;
      OP_XOR:  alu_value = a_ext ^ b_ext;
      // Multiplies go to the other unit
      default: alu_value = '0;
    endcase
  end

  // Unit stays occupied while holding its result
  assign busy = done;

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      done <= 1'b0;
    end else if (start) begin
      done <= 1'b1;
    end else if (grant) begin
      done <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      result.tag  <= unit_req.tag;
      result.data <= alu_value;
    end
  end

endmodule

`default_nettype wire

/* verilog/op_dispatch.sv */
// --------------------
// Issue stage of the core.
// Takes one operation per issue strobe, reserves its buffer slot and
// starts the unit picked by the opcode in the same cycle.
// op_busy tells the requester to hold off.
// --------------------
`timescale 1ns/1ps
`default_nettype none

module op_dispatch
  import rob_pkg::*;
(
  input  wire                        clock,
  input  wire                        resetn,
  input  wire                        op_issue,
  input  op_req_t                    op_req,
  output logic                       op_busy,
  output logic                       reserve,
  input  wire [ROB_INDEX_WIDTH-1:0]  reserve_index,
  input  wire                        reserve_full,
  input  wire                        alu_busy,
  input  wire                        mul_busy,
  output logic                       alu_start,
  output logic                       mul_start,
  output unit_req_t                  unit_req
);

  logic use_mul;
  logic target_busy;
  logic accept;

  // Opcode decode
  always_comb begin
    case (op_req.opcode)
      OP_ADD, OP_SUB, OP_XOR: use_mul = 1'b0;
      OP_MUL:                 use_mul = 1'b1;
      default:                use_mul = 1'b0;
    endcase
  end

  // Busy depends on the opcode currently offered
  assign target_busy = use_mul ? mul_busy : alu_busy;
  assign op_busy     = reserve_full | target_busy;

  // Issue counts only while not busy
  assign accept    = op_issue & ~op_busy;
  assign reserve   = accept;
  assign alu_start = accept & ~use_mul;
  assign mul_start = accept & use_mul;

  // Tag is the slot being reserved this cycle
  always_comb begin
    unit_req.tag       = reserve_index;
    unit_req.opcode    = op_req.opcode;
    unit_req.operand_a = op_req.operand_a;
    unit_req.operand_b = op_req.operand_b;
  end

endmodule

`default_nettype wire

/* verilog/reorder_buffer.sv */
// --------------------
// Reorder buffer for unit results.
// Slots are reserved in issue order and the slot index is the tag.
// Units write results at their tags in any order.
// The head slot is presented once it holds a result, and a read frees it.
// --------------------
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
  import rob_pkg::*;
(
  input  wire                        clock,
  input  wire                        resetn,
  // Reservation side
  input  wire                        reserve,
  output logic [ROB_INDEX_WIDTH-1:0] reserve_index,
  output logic                       reserve_full,
  output logic                       reserve_empty,
  // Write side
  input  wire                        write_enable,
  input  unit_result_t               write_result,
  // Read side
  output logic                       read_valid,
  output logic [RESULT_WIDTH-1:0]    read_data,
  input  wire                        read_enable
);

  // Result storage, no reset needed
  logic [RESULT_WIDTH-1:0] data_mem [ROB_DEPTH];

  // Per-slot state
  logic [ROB_DEPTH-1:0] reserved;
  logic [ROB_DEPTH-1:0] reserved_next;
  logic [ROB_DEPTH-1:0] valid;
  logic [ROB_DEPTH-1:0] valid_next;

  // Pointers carry an extra wrap bit
  logic [ROB_INDEX_WIDTH:0] reserve_ptr;
  logic [ROB_INDEX_WIDTH:0] reserve_ptr_next;
  logic [ROB_INDEX_WIDTH:0] read_ptr;
  logic [ROB_INDEX_WIDTH:0] read_ptr_next;

  logic [ROB_INDEX_WIDTH-1:0] head_index;
  logic                       same_index;
  logic                       same_wrap;

  assign reserve_index = reserve_ptr[ROB_INDEX_WIDTH-1:0];
  assign head_index    = read_ptr[ROB_INDEX_WIDTH-1:0];

  // Head is readable only when reserved and written
  assign read_valid = valid[head_index] & reserved[head_index];
  assign read_data  = data_mem[head_index];

  always_comb begin
    reserve_ptr_next = reserve_ptr;
    read_ptr_next    = read_ptr;
    reserved_next    = reserved;
    valid_next       = valid;
    // Hand out the next tag
    if (reserve && !reserve_full) begin
      reserved_next[reserve_index] = 1'b1;
      reserve_ptr_next = reserve_ptr + 1'b1;
    end
    // Result lands at its own tag
    if (write_enable) begin
      valid_next[write_result.tag] = 1'b1;
    end
    // Retire the head
    if (read_enable && read_valid) begin
      reserved_next[head_index] = 1'b0;
      valid_next[head_index]    = 1'b0;
      read_ptr_next = read_ptr + 1'b1;
    end
  end

  // Flags compare the next pointers so they are ready right after the edge
  assign same_index = reserve_ptr_next[ROB_INDEX_WIDTH-1:0] ==
                      read_ptr_next[ROB_INDEX_WIDTH-1:0];
  assign same_wrap  = reserve_ptr_next[ROB_INDEX_WIDTH] == read_ptr_next[ROB_INDEX_WIDTH];

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      reserve_ptr   <= '0;
      read_ptr      <= '0;
      reserved      <= '0;
      valid         <= '0;
      reserve_full  <= 1'b0;
      reserve_empty <= 1'b1;
    end else begin
      reserve_ptr   <= reserve_ptr_next;
      read_ptr      <= read_ptr_next;
      reserved      <= reserved_next;
      valid         <= valid_next;
      reserve_full  <= same_index & ~same_wrap;
      reserve_empty <= same_index & same_wrap;
    end
  end

  always_ff @(posedge clock) begin
    if (write_enable) begin
      data_mem[write_result.tag] <= write_result.data;
    end
  end

endmodule

`default_nettype wire

/* verilog/rob_pkg.sv */
// --------------------
// Shared widths, depth and types for the reorder-buffer arithmetic core.
// Every RTL block takes what it needs with a wildcard import.
// Compile this file before any module that imports it.
// --------------------
`default_nettype none

package rob_pkg;

  // Operand and result widths
  localparam int OPERAND_WIDTH = 8;
  localparam int RESULT_WIDTH = 16;

  // Reorder buffer geometry, the slot index doubles as the tag
  localparam int ROB_DEPTH = 8;
  localparam int ROB_INDEX_WIDTH = 3;

  // Shift-add multiplier, one iteration per multiplier bit
  localparam int MUL_CYCLES = OPERAND_WIDTH;
  localparam int MUL_COUNT_WIDTH = $clog2(MUL_CYCLES);

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_XOR = 2'd2,
    OP_MUL = 2'd3
  } opcode_t;

  // Operation as issued by the requester
  typedef struct packed {
    opcode_t                  opcode;
    logic [OPERAND_WIDTH-1:0] operand_a;
    logic [OPERAND_WIDTH-1:0] operand_b;
  } op_req_t;

  // Operation routed to a unit, tagged with its buffer slot
  typedef struct packed {
    logic [ROB_INDEX_WIDTH-1:0] tag;
    opcode_t                    opcode;
    logic [OPERAND_WIDTH-1:0]   operand_a;
    logic [OPERAND_WIDTH-1:0]   operand_b;
  } unit_req_t;

  // Finished result on its way to the buffer
  typedef struct packed {
    logic [ROB_INDEX_WIDTH-1:0] tag;
    logic [RESULT_WIDTH-1:0]    data;
  } unit_result_t;

endpackage

`default_nettype wire
